// ==== zxuno_pkg.sv ====
package zxuno_pkg;

   // -------------------------------------------------------------------------
   // CPU I/O ports of the register bank
   // -------------------------------------------------------------------------
   localparam logic [15:0] zxuno_addr_port = 16'hFC3B;
   localparam logic [15:0] zxuno_data_port = 16'hFD3B;

   // Register numbers behind the data port
   localparam logic [7:0] reg_scandblctrl = 8'h0B;
   localparam logic [7:0] reg_rasterline  = 8'h0C;
   localparam logic [7:0] reg_rasterctrl  = 8'h0D;
   localparam logic [7:0] reg_devoptions  = 8'h0E;
   localparam logic [7:0] reg_devopts2    = 8'h0F;
   localparam logic [7:0] reg_scratch     = 8'hFE;
   localparam logic [7:0] reg_coreid      = 8'hFF;

   // -------------------------------------------------------------------------
   // Core identification string
   // -------------------------------------------------------------------------
   localparam int coreid_len   = 8;
   localparam int coreid_sel_w = $clog2(coreid_len);
   // One extra state for the terminating zero
   localparam int coreid_idx_w = $clog2(coreid_len + 1);
   localparam logic [coreid_idx_w-1:0] coreid_end = coreid_idx_w'(coreid_len);
   // Element 0 holds the first character
   localparam logic [0:coreid_len-1][7:0] coreid_text = "ZXREGB01";

   // -------------------------------------------------------------------------
   // Register byte layouts
   // -------------------------------------------------------------------------
   typedef struct packed {
      logic disable_spisd;
      logic enable_timexmmu;
      logic disable_romsel1f;
      logic disable_romsel7f;
      logic disable_1ffd;
      logic disable_7ffd;
      logic disable_turboay;
      logic disable_ay;
   } devoptions_flags_t;

   typedef union packed {
      logic [7:0]        raw;
      devoptions_flags_t flags;
   } devoptions_t;

   // Reserved bits are kept and returned on read
   typedef struct packed {
      logic [4:0] reserved;
      logic       disable_radas;
      logic       disable_timexscr;
      logic       disable_ulaplus;
   } devopts2_flags_t;

   typedef union packed {
      logic [7:0]      raw;
      devopts2_flags_t flags;
   } devopts2_t;

   typedef struct packed {
      logic [1:0] turbo_enable;
      logic       reserved;
      logic [2:0] freq_option;
      logic       scanlines_enable;
      logic       vga_enable;
   } scandblctrl_flags_t;

   typedef union packed {
      logic [7:0]         raw;
      scandblctrl_flags_t flags;
   } scandblctrl_t;

endpackage

// ==== zxuno_regaddr.sv ====
module zxuno_regaddr (
   input  logic        cpuclkplain,
   input  logic        reset,
   input  logic [15:0] a,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic [7:0]  din,
   output logic [7:0]  zxuno_addr,
   output logic        zxuno_regrd,
   output logic        zxuno_regwr,
   output logic        regaddr_changed,
   output logic [7:0]  addr_dout,
   output logic        addr_oe_n
);

   logic addr_sel;
   logic data_sel;
   logic addr_wr;
   logic addr_wr_q;

   // Full 16-bit port decode
   assign addr_sel = !iorq_n && (a == zxuno_pkg::zxuno_addr_port);
   assign data_sel = !iorq_n && (a == zxuno_pkg::zxuno_data_port);
   assign addr_wr  = addr_sel && !wr_n;

   // Data port strobes seen by every register block
   assign zxuno_regrd = data_sel && !rd_n;
   assign zxuno_regwr = data_sel && !wr_n;

   // High only in the first cycle of an address write,
   // so a held strobe still gives a single pulse
   assign regaddr_changed = addr_wr && !addr_wr_q;

   always_ff @(posedge cpuclkplain) begin
      if (reset) begin
         zxuno_addr <= 8'h00;
         addr_wr_q  <= 1'b0;
      end else begin
         addr_wr_q <= addr_wr;
         if (addr_wr) begin
            zxuno_addr <= din;
         end
      end
   end

   // Read-back of the current register number
   assign addr_dout = zxuno_addr;
   assign addr_oe_n = !(addr_sel && !rd_n);

endmodule

// ==== coreid.sv ====
module coreid (
   input  logic       cpuclkplain,
   input  logic       reset,
   input  logic [7:0] zxuno_addr,
   input  logic       zxuno_regrd,
   input  logic       regaddr_changed,
   output logic [7:0] dout,
   output logic       oe_n
);

   logic [zxuno_pkg::coreid_idx_w-1:0] idx;
   logic [zxuno_pkg::coreid_sel_w-1:0] char_sel;
   logic                               id_rd;
   logic                               id_rd_q;
   logic                               at_end;

   assign id_rd  = zxuno_regrd && (zxuno_addr == zxuno_pkg::reg_coreid);
   assign at_end = (idx == zxuno_pkg::coreid_end);

   // Index moves on at the end of the first cycle of each read access.
   // It parks on the terminator until the address is written again
   always_ff @(posedge cpuclkplain) begin
      if (reset) begin
         idx     <= '0;
         id_rd_q <= 1'b0;
      end else begin
         id_rd_q <= id_rd;
         if (regaddr_changed) begin
            idx <= '0;
         end else if (id_rd && !id_rd_q && !at_end) begin
            idx <= idx + 1'b1;
         end
      end
   end

   assign char_sel = idx[zxuno_pkg::coreid_sel_w-1:0];

   // Zero byte once the string is exhausted
   always_comb begin
      if (at_end) begin
         dout = 8'h00;
      end else begin
         dout = zxuno_pkg::coreid_text[char_sel];
      end
   end

   assign oe_n = !id_rd;

endmodule

// ==== config_regs.sv ====
module config_regs (
   input  logic       cpuclkplain,
   input  logic       reset,
   input  logic [7:0] zxuno_addr,
   input  logic       zxuno_regrd,
   input  logic       zxuno_regwr,
   input  logic [7:0] din,
   output logic [7:0] dout,
   output logic       oe_n,
   output logic       disable_ay,
   output logic       disable_turboay,
   output logic       disable_7ffd,
   output logic       disable_1ffd,
   output logic       disable_romsel7f,
   output logic       disable_romsel1f,
   output logic       enable_timexmmu,
   output logic       disable_spisd,
   output logic       disable_ulaplus,
   output logic       disable_timexscr,
   output logic       disable_radas,
   output logic       vga_enable,
   output logic       scanlines_enable,
   output logic [2:0] freq_option,
   output logic [1:0] turbo_enable
);

   logic [7:0]              scratch;
   zxuno_pkg::devoptions_t  devoptions;
   zxuno_pkg::devopts2_t    devopts2;
   zxuno_pkg::scandblctrl_t scandblctrl;
   logic                    hit;

   // -------------------------------------------------------------------------
   // Register writes
   // -------------------------------------------------------------------------
   always_ff @(posedge cpuclkplain) begin
      if (reset) begin
         scratch         <= 8'h00;
         devoptions.raw  <= 8'h00;
         devopts2.raw    <= 8'h00;
         scandblctrl.raw <= 8'h00;
      end else if (zxuno_regwr) begin
         case (zxuno_addr)
            zxuno_pkg::reg_scratch:     scratch         <= din;
            zxuno_pkg::reg_devoptions:  devoptions.raw  <= din;
            zxuno_pkg::reg_devopts2:    devopts2.raw    <= din;
            zxuno_pkg::reg_scandblctrl: scandblctrl.raw <= din;
            default: ;
         endcase
      end
   end

   // -------------------------------------------------------------------------
   // Read-back of the addressed byte
   // -------------------------------------------------------------------------
   always_comb begin
      dout = 8'hFF;
      hit  = 1'b1;
      case (zxuno_addr)
         zxuno_pkg::reg_scratch:     dout = scratch;
         zxuno_pkg::reg_devoptions:  dout = devoptions.raw;
         zxuno_pkg::reg_devopts2:    dout = devopts2.raw;
         zxuno_pkg::reg_scandblctrl: dout = scandblctrl.raw;
         default:                    hit  = 1'b0;
      endcase
   end

   assign oe_n = !(zxuno_regrd && hit);

   // Device enable flags
   assign disable_ay       = devoptions.flags.disable_ay;
   assign disable_turboay  = devoptions.flags.disable_turboay;
   assign disable_7ffd     = devoptions.flags.disable_7ffd;
   assign disable_1ffd     = devoptions.flags.disable_1ffd;
   assign disable_romsel7f = devoptions.flags.disable_romsel7f;
   assign disable_romsel1f = devoptions.flags.disable_romsel1f;
   assign enable_timexmmu  = devoptions.flags.enable_timexmmu;
   assign disable_spisd    = devoptions.flags.disable_spisd;

   assign disable_ulaplus  = devopts2.flags.disable_ulaplus;
   assign disable_timexscr = devopts2.flags.disable_timexscr;
   assign disable_radas    = devopts2.flags.disable_radas;

   // Scandoubler and CPU speed control
   assign vga_enable       = scandblctrl.flags.vga_enable;
   assign scanlines_enable = scandblctrl.flags.scanlines_enable;
   assign freq_option      = scandblctrl.flags.freq_option;
   assign turbo_enable     = scandblctrl.flags.turbo_enable;

endmodule

// ==== rasterint_ctrl.sv ====
module rasterint_ctrl (
   input  logic       cpuclkplain,
   input  logic       reset,
   input  logic [7:0] zxuno_addr,
   input  logic       zxuno_regrd,
   input  logic       zxuno_regwr,
   input  logic [7:0] din,
   input  logic       raster_int_in_progress,
   output logic [7:0] dout,
   output logic       oe_n,
   output logic [8:0] raster_line,
   output logic       rasterint_enable,
   output logic       vretraceint_disable
);

   logic hit;

   // Line low byte in $0C, line bit 8 and enables in $0D
   always_ff @(posedge cpuclkplain) begin
      if (reset) begin
         raster_line         <= 9'd0;
         rasterint_enable    <= 1'b0;
         vretraceint_disable <= 1'b0;
      end else if (zxuno_regwr) begin
         if (zxuno_addr == zxuno_pkg::reg_rasterline) begin
            raster_line[7:0] <= din;
         end else if (zxuno_addr == zxuno_pkg::reg_rasterctrl) begin
            raster_line[8]      <= din[0];
            rasterint_enable    <= din[1];
            vretraceint_disable <= din[2];
         end
      end
   end

   // Control read also reports a raster interrupt being serviced
   always_comb begin
      dout = 8'hFF;
      hit  = 1'b1;
      case (zxuno_addr)
         zxuno_pkg::reg_rasterline: begin
            dout = raster_line[7:0];
         end
         zxuno_pkg::reg_rasterctrl: begin
            dout = {4'b0000, raster_int_in_progress, vretraceint_disable,
                    rasterint_enable, raster_line[8]};
         end
         default: begin
            hit = 1'b0;
         end
      endcase
   end

   assign oe_n = !(zxuno_regrd && hit);

endmodule

// ==== zxuno_regbank.sv ====
module zxuno_regbank (
   input  logic        cpuclkplain,
   input  logic        reset,
   input  logic [15:0] a,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic [7:0]  din,
   input  logic        raster_int_in_progress,
   output logic [7:0]  dout,
   output logic        oe_n,
   output logic        disable_ay,
   output logic        disable_turboay,
   output logic        disable_7ffd,
   output logic        disable_1ffd,
   output logic        disable_romsel7f,
   output logic        disable_romsel1f,
   output logic        enable_timexmmu,
   output logic        disable_spisd,
   output logic        disable_ulaplus,
   output logic        disable_timexscr,
   output logic        disable_radas,
   output logic        vga_enable,
   output logic        scanlines_enable,
   output logic [2:0]  freq_option,
   output logic [1:0]  turbo_enable,
   output logic [8:0]  raster_line,
   output logic        rasterint_enable,
   output logic        vretraceint_disable
);

   // Shared register bus
   logic [7:0] zxuno_addr;
   logic       zxuno_regrd;
   logic       zxuno_regwr;
   logic       regaddr_changed;

   // Read sources
   logic [7:0] addr_dout;
   logic       addr_oe_n;
   logic [7:0] coreid_dout;
   logic       coreid_oe_n;
   logic [7:0] cfg_dout;
   logic       cfg_oe_n;
   logic [7:0] raster_dout;
   logic       raster_oe_n;

   zxuno_regaddr regaddr_inst (
      .cpuclkplain, .reset, .a, .iorq_n, .rd_n, .wr_n, .din,
      .zxuno_addr, .zxuno_regrd, .zxuno_regwr, .regaddr_changed,
      .addr_dout, .addr_oe_n
   );

   coreid coreid_inst (
      .cpuclkplain, .reset, .zxuno_addr, .zxuno_regrd, .regaddr_changed,
      .dout (coreid_dout),
      .oe_n (coreid_oe_n)
   );

   config_regs config_regs_inst (
      .cpuclkplain, .reset, .zxuno_addr, .zxuno_regrd, .zxuno_regwr, .din,
      .dout (cfg_dout),
      .oe_n (cfg_oe_n),
      .disable_ay, .disable_turboay, .disable_7ffd, .disable_1ffd,
      .disable_romsel7f, .disable_romsel1f, .enable_timexmmu, .disable_spisd,
      .disable_ulaplus, .disable_timexscr, .disable_radas,
      .vga_enable, .scanlines_enable, .freq_option, .turbo_enable
   );

   rasterint_ctrl rasterint_inst (
      .cpuclkplain, .reset, .zxuno_addr, .zxuno_regrd, .zxuno_regwr, .din,
      .raster_int_in_progress,
      .dout (raster_dout),
      .oe_n (raster_oe_n),
      .raster_line, .rasterint_enable, .vretraceint_disable
   );

   // -------------------------------------------------------------------------
   // CPU read multiplexer
   // -------------------------------------------------------------------------
   // First active source wins
   always_comb begin
      oe_n = 1'b0;
      case (1'b0)
         addr_oe_n:   dout = addr_dout;
         coreid_oe_n: dout = coreid_dout;
         cfg_oe_n:    dout = cfg_dout;
         raster_oe_n: dout = raster_dout;
         default: begin
            // Idle bus
            dout = 8'hFF;
            oe_n = 1'b1;
         end
      endcase
   end

endmodule

// ==== tb_zxuno_regbank.sv ====
module tb_zxuno_regbank;

   localparam int reset_cycles  = 16;
   localparam int addr_trials   = 16;
   localparam int cfg_trials    = 32;
   localparam int raster_trials = 24;
   localparam int id_reads      = 12;
   localparam int mix_ops       = 400;
   // Bus accesses per trial are 4, 3, 6, id_reads + 1 for two rounds, then 1
   localparam int total_accesses = addr_trials * 4 + cfg_trials * 3 + raster_trials * 6
                                   + 2 * (id_reads + 1) + mix_ops;

   localparam logic [7:0] id_chars [0:7] = '{"Z", "X", "R", "E", "G", "B", "0", "1"};
   localparam logic [7:0] reg_table [0:6] = '{zxuno_pkg::reg_scratch, zxuno_pkg::reg_coreid,
      zxuno_pkg::reg_scandblctrl, zxuno_pkg::reg_rasterline, zxuno_pkg::reg_rasterctrl,
      zxuno_pkg::reg_devoptions, zxuno_pkg::reg_devopts2};

   logic        cpuclkplain = 1'b0;
   logic        reset;
   logic [15:0] a;
   logic        iorq_n, rd_n, wr_n;
   logic [7:0]  din;
   logic        raster_int_in_progress;
   logic [7:0]  dout;
   logic        oe_n;
   logic        disable_ay, disable_turboay, disable_7ffd, disable_1ffd;
   logic        disable_romsel7f, disable_romsel1f, enable_timexmmu, disable_spisd;
   logic        disable_ulaplus, disable_timexscr, disable_radas;
   logic        vga_enable, scanlines_enable;
   logic [2:0]  freq_option;
   logic [1:0]  turbo_enable;
   logic [8:0]  raster_line;
   logic        rasterint_enable, vretraceint_disable;

   // Register model
   logic [7:0]              m_addr, m_scratch;
   zxuno_pkg::devoptions_t  m_devopt;
   zxuno_pkg::devopts2_t    m_devopt2;
   zxuno_pkg::scandblctrl_t m_scandbl;
   logic [8:0]              m_rline;
   logic                    m_rint_en, m_vret_dis;
   int                      m_id_idx;

   logic [31:0] lcg_state = 32'd28082;
   int          checks = 0;
   int          errors = 0;
   int          test_start_errors = 0;
   logic [7:0]  r;
   int          k;

   zxuno_regbank zxuno_regbank_inst (.*);

   always #5 cpuclkplain = ~cpuclkplain;

   function logic [7:0] rand_byte();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[23:16];
   endfunction

   function bit is_known(input logic [7:0] num);
      foreach (reg_table[i]) begin
         if (reg_table[i] == num) begin
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   // ------------------------------------------------------------------------
   // Compare tasks
   // ------------------------------------------------------------------------
   task automatic fail_value(input string name, input logic [8:0] got, input logic [8:0] exp);
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) fail_value(name, 9'(got), 9'(exp));
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      if (got !== exp) fail_value(name, 9'(got), 9'(exp));
   endtask

   task automatic check_raster_line(input string name, input logic [8:0] got,
                                    input logic [8:0] exp);
      checks++;
      if (got !== exp) fail_value(name, got, exp);
   endtask

   task automatic check_devoptions(input string name, input zxuno_pkg::devoptions_t got,
                                   input zxuno_pkg::devoptions_t exp);
      checks++;
      if (got.raw !== exp.raw) fail_value(name, 9'(got.raw), 9'(exp.raw));
   endtask

   // Reserved bits have no output pin
   task automatic check_devopts2(input string name, input zxuno_pkg::devopts2_t got,
                                 input zxuno_pkg::devopts2_t exp);
      checks++;
      got.flags.reserved = '0;
      exp.flags.reserved = '0;
      if (got.raw !== exp.raw) fail_value(name, 9'(got.raw), 9'(exp.raw));
   endtask

   task automatic check_scandblctrl(input string name, input zxuno_pkg::scandblctrl_t got,
                                    input zxuno_pkg::scandblctrl_t exp);
      checks++;
      got.flags.reserved = 1'b0;
      exp.flags.reserved = 1'b0;
      if (got.raw !== exp.raw) fail_value(name, 9'(got.raw), 9'(exp.raw));
   endtask

   task automatic check_outputs();
      zxuno_pkg::devoptions_t  got_opt;
      zxuno_pkg::devopts2_t    got_opt2;
      zxuno_pkg::scandblctrl_t got_sdc;
      #1;
      got_opt.raw  = {disable_spisd, enable_timexmmu, disable_romsel1f, disable_romsel7f,
                      disable_1ffd, disable_7ffd, disable_turboay, disable_ay};
      got_opt2.raw = {5'b00000, disable_radas, disable_timexscr, disable_ulaplus};
      got_sdc.raw  = {turbo_enable, 1'b0, freq_option, scanlines_enable, vga_enable};
      check_devoptions("devoptions flags", got_opt, m_devopt);
      check_devopts2("devopts2 flags", got_opt2, m_devopt2);
      check_scandblctrl("scandblctrl flags", got_sdc, m_scandbl);
      check_raster_line("raster_line", raster_line, m_rline);
      check_bit("rasterint_enable", rasterint_enable, m_rint_en);
      check_bit("vretraceint_disable", vretraceint_disable, m_vret_dis);
      check_bit("oe_n idle", oe_n, 1'b1);
   endtask

   // ------------------------------------------------------------------------
   // Bus accesses with model updates
   // ------------------------------------------------------------------------
   task automatic write_port(input logic [15:0] port, input logic [7:0] data);
      @(negedge cpuclkplain);
      a = port;
      din = data;
      iorq_n = 1'b0;
      wr_n = 1'b0;
      @(negedge cpuclkplain);
      iorq_n = 1'b1;
      wr_n = 1'b1;
   endtask

   task automatic read_port(input logic [15:0] port, input logic rip,
                            output logic [7:0] d, output logic o);
      @(negedge cpuclkplain);
      a = port;
      raster_int_in_progress = rip;
      iorq_n = 1'b0;
      rd_n = 1'b0;
      #4;
      d = dout;
      o = oe_n;
      @(negedge cpuclkplain);
      iorq_n = 1'b1;
      rd_n = 1'b1;
   endtask

   task automatic addr_write(input logic [7:0] num);
      write_port(zxuno_pkg::zxuno_addr_port, num);
      m_addr   = num;
      m_id_idx = 0;
      check_outputs();
   endtask

   task automatic addr_read();
      logic [7:0] d;
      logic       o;
      read_port(zxuno_pkg::zxuno_addr_port, 1'b0, d, o);
      check_bit("oe_n", o, 1'b0);
      check_byte("dout addr", d, m_addr);
      check_outputs();
   endtask

   task automatic data_write(input logic [7:0] v);
      write_port(zxuno_pkg::zxuno_data_port, v);
      case (m_addr)
         zxuno_pkg::reg_scratch:     m_scratch = v;
         zxuno_pkg::reg_devoptions:  m_devopt.raw = v;
         zxuno_pkg::reg_devopts2:    m_devopt2.raw = v;
         zxuno_pkg::reg_scandblctrl: m_scandbl.raw = v;
         zxuno_pkg::reg_rasterline:  m_rline[7:0] = v;
         zxuno_pkg::reg_rasterctrl: begin
            m_rline[8] = v[0];
            m_rint_en  = v[1];
            m_vret_dis = v[2];
         end
         default: ;
      endcase
      check_outputs();
   endtask

   task automatic data_read();
      logic [7:0] d, exp_d;
      logic       o, exp_o, rip;
      rip   = rand_byte() > 8'h7F;
      read_port(zxuno_pkg::zxuno_data_port, rip, d, o);
      exp_o = 1'b0;
      case (m_addr)
         zxuno_pkg::reg_scratch:     exp_d = m_scratch;
         zxuno_pkg::reg_devoptions:  exp_d = m_devopt.raw;
         zxuno_pkg::reg_devopts2:    exp_d = m_devopt2.raw;
         zxuno_pkg::reg_scandblctrl: exp_d = m_scandbl.raw;
         zxuno_pkg::reg_rasterline:  exp_d = m_rline[7:0];
         zxuno_pkg::reg_rasterctrl:  exp_d = {4'h0, rip, m_vret_dis, m_rint_en, m_rline[8]};
         zxuno_pkg::reg_coreid: begin
            // One character per access, then zeros
            exp_d = (m_id_idx < 8) ? id_chars[m_id_idx] : 8'h00;
            if (m_id_idx < 8) m_id_idx++;
         end
         default: begin
            exp_d = 8'hFF;
            exp_o = 1'b1;
         end
      endcase
      check_bit("oe_n", o, exp_o);
      check_byte("dout data", d, exp_d);
      check_outputs();
   endtask

   task automatic report_test(input string name);
      $display("%-24s %0d errors", name, errors - test_start_errors);
      test_start_errors = errors;
   endtask

   // ------------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------------
   initial begin
      reset = 1'b1;
      a = 16'h0000;
      iorq_n = 1'b1;
      rd_n = 1'b1;
      wr_n = 1'b1;
      din = 8'h00;
      raster_int_in_progress = 1'b0;
      m_addr = 8'h00;
      m_scratch = 8'h00;
      m_devopt = '0;
      m_devopt2 = '0;
      m_scandbl = '0;
      m_rline = 9'd0;
      m_rint_en = 1'b0;
      m_vret_dis = 1'b0;
      m_id_idx = 0;
      repeat (reset_cycles) @(posedge cpuclkplain);
      @(negedge cpuclkplain);
      reset = 1'b0;

      check_outputs();
      check_byte("dout idle", dout, 8'hFF);
      report_test("reset values");

      for (int i = 0; i < addr_trials; i++) begin
         addr_write(rand_byte());
         addr_read();
         do begin
            r = rand_byte();
         end while (is_known(r));
         addr_write(r);
         data_read();
      end
      report_test("address port");

      for (int i = 0; i < cfg_trials; i++) begin
         k = rand_byte() % 4;
         addr_write(k == 0 ? zxuno_pkg::reg_scratch : k == 1 ? zxuno_pkg::reg_devoptions :
                    k == 2 ? zxuno_pkg::reg_devopts2 : zxuno_pkg::reg_scandblctrl);
         data_write(rand_byte());
         data_read();
      end
      report_test("config registers");

      for (int i = 0; i < raster_trials; i++) begin
         addr_write(zxuno_pkg::reg_rasterline);
         data_write(rand_byte());
         data_read();
         addr_write(zxuno_pkg::reg_rasterctrl);
         data_write(rand_byte());
         data_read();
      end
      report_test("raster registers");

      repeat (2) begin
         addr_write(zxuno_pkg::reg_coreid);
         repeat (id_reads) data_read();
      end
      report_test("core id");

      // Mixed traffic
      // Last table slot stands for any register number
      for (int i = 0; i < mix_ops; i++) begin
         case (rand_byte() % 4)
            0: begin
               k = rand_byte() % 8;
               addr_write(k < 7 ? reg_table[k] : rand_byte());
            end
            1: data_write(rand_byte());
            2: data_read();
            default: addr_read();
         endcase
      end
      report_test("random mix");

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      repeat (total_accesses * 4 + reset_cycles) @(posedge cpuclkplain);
      $display("Timeout: the tests did not complete in the expected time");
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== tb.f ====
zxuno_pkg.sv
zxuno_regaddr.sv
coreid.sv
config_regs.sv
rasterint_ctrl.sv
zxuno_regbank.sv
tb_zxuno_regbank.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_zxuno_regbank -f tb.f -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@if ! grep -q "TEST PASSED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
